//--- ex_stage.f
hw/ex_isa_pkg.sv
hw/ex_bus_pkg.sv
hw/ex_stage_reg.sv
hw/ex_alu.sv
hw/ex_branch_resolve.sv
hw/ex_mem_request.sv
hw/ex_stage.sv
verif/ex_stage_checker.sv
verif/ex_stage_tb.sv

//--- hw/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
    input  ex_bus_pkg::id_ex_t          cur_i,
    input  ex_bus_pkg::fwd_t            fwd_rs_i,
    input  ex_bus_pkg::fwd_t            fwd_rt_i,
    output logic [ex_isa_pkg::xlen-1:0] rs_val_o,
    output logic [ex_isa_pkg::xlen-1:0] rt_val_o,
    output logic [ex_isa_pkg::xlen-1:0] result_o,
    output logic                        ov_o
);

    import ex_isa_pkg::*;

    logic [xlen-1:0] imm_sext;
    logic [xlen-1:0] imm_zext;
    logic [xlen-1:0] shamt_zext;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] sum;
    logic [xlen-1:0] diff;
    logic [4:0]      sh_amt;
    logic            add_ov;
    logic            sub_ov;

    // forwarded values win over the register file read
    assign rs_val_o = fwd_rs_i.sel ? fwd_rs_i.data : cur_i.rs_data;
    assign rt_val_o = fwd_rt_i.sel ? fwd_rt_i.data : cur_i.rt_data;

    assign imm_sext   = {{(xlen-16){cur_i.inst.i_fmt.imm16[15]}}, cur_i.inst.i_fmt.imm16};
    assign imm_zext   = {{(xlen-16){1'b0}}, cur_i.inst.i_fmt.imm16};
    assign shamt_zext = {{(xlen-5){1'b0}}, cur_i.inst.i_fmt.imm16[10:6]};

    always_comb begin
        case (cur_i.src1_sel)
            src1_pc:    src1 = cur_i.pc;
            src1_shamt: src1 = shamt_zext;
            default:    src1 = rs_val_o;
        endcase
    end

    always_comb begin
        case (cur_i.src2_sel)
            src2_imm_sext: src2 = imm_sext;
            src2_link:     src2 = link_offset;
            src2_imm_zext: src2 = imm_zext;
            default:       src2 = rt_val_o;
        endcase
    end

    assign sum    = src1 + src2;
    assign diff   = src1 - src2;
    assign sh_amt = src1[4:0];

    always_comb begin
        case (cur_i.alu_op)
            alu_add, alu_addu: result_o = sum;
            alu_sub, alu_subu: result_o = diff;
            alu_and:    result_o = src1 & src2;
            alu_or:     result_o = src1 | src2;
            alu_xor:    result_o = src1 ^ src2;
            alu_nor:    result_o = ~(src1 | src2);
            alu_slt:    result_o = {{(xlen-1){1'b0}}, $signed(src1) < $signed(src2)};
            alu_sltu:   result_o = {{(xlen-1){1'b0}}, src1 < src2};
            alu_sll:    result_o = src2 << sh_amt;
            alu_srl:    result_o = src2 >> sh_amt;
            alu_sra:    result_o = $signed(src2) >>> sh_amt;
            alu_lui:    result_o = {src2[15:0], 16'b0};
            alu_pass_b: result_o = src2;
            default:    result_o = '0;
        endcase
    end

    // signed overflow, trapping ops only
    assign add_ov = (src1[xlen-1] == src2[xlen-1]) && (sum[xlen-1] != src1[xlen-1]);
    assign sub_ov = (src1[xlen-1] != src2[xlen-1]) && (diff[xlen-1] != src1[xlen-1]);
    assign ov_o   = ((cur_i.alu_op == alu_add) && add_ov)
                 || ((cur_i.alu_op == alu_sub) && sub_ov);

endmodule

//--- hw/ex_branch_resolve.sv
`timescale 1ns/1ps

module ex_branch_resolve (
    input  ex_bus_pkg::id_ex_t          cur_i,
    input  logic [ex_isa_pkg::xlen-1:0] rs_val_i,
    input  logic [ex_isa_pkg::xlen-1:0] rt_val_i,
    input  ex_bus_pkg::bp_t             bp_i,
    output ex_bus_pkg::redirect_t       redirect_o
);

    import ex_isa_pkg::*;

    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] br_off;
    logic [xlen-1:0] real_target;
    logic            real_taken;
    logic            rs_eq_rt;
    logic            rs_neg;
    logic            rs_zero;
    logic            is_branch;
    logic            jump_err;
    logic            nojump_err;

    assign pc_plus4 = cur_i.pc + xlen'(4);
    assign br_off   = {{(xlen-18){cur_i.inst.i_fmt.imm16[15]}}, cur_i.inst.i_fmt.imm16, 2'b00};

    assign rs_eq_rt = (rs_val_i == rt_val_i);
    assign rs_neg   = rs_val_i[xlen-1];
    assign rs_zero  = (rs_val_i == '0);

    always_comb begin
        real_taken  = 1'b0;
        real_target = pc_plus4 + br_off;
        case (cur_i.br_op)
            br_beq:  real_taken = rs_eq_rt;
            br_bne:  real_taken = !rs_eq_rt;
            br_bgez: real_taken = !rs_neg;
            br_bgtz: real_taken = !rs_neg && !rs_zero;
            br_blez: real_taken = rs_neg || rs_zero;
            br_bltz: real_taken = rs_neg;
            br_j: begin
                real_taken  = 1'b1;
                real_target = {pc_plus4[xlen-1 -: 4], cur_i.inst.j_fmt.index26, 2'b00};
            end
            br_jr: begin
                real_taken  = 1'b1;
                real_target = rs_val_i;
            end
            default: real_taken = 1'b0;
        endcase
    end

    // compare against what fetch guessed
    assign is_branch  = cur_i.valid && (cur_i.br_op != br_none);
    assign jump_err   = real_taken && (!bp_i.taken || (bp_i.target != real_target));
    assign nojump_err = bp_i.taken && !real_taken;

    always_comb begin
        redirect_o.valid  = is_branch && (jump_err || nojump_err);
        redirect_o.target = '0;
        if (redirect_o.valid) begin
            redirect_o.target = jump_err ? real_target : cur_i.pc + link_offset;
        end
    end

endmodule

//--- hw/ex_bus_pkg.sv
package ex_bus_pkg;

    import ex_isa_pkg::*;

    // decoded instruction handed over by the decode stage
    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        inst_word_u            inst;
        alu_op_t               alu_op;
        src1_sel_t             src1_sel;
        src2_sel_t             src2_sel;
        br_op_t                br_op;
        mem_op_t               mem_op;
        logic                  rf_we;
        logic [reg_addr_w-1:0] rf_waddr;
        logic [xlen-1:0]       rs_data;
        logic [xlen-1:0]       rt_data;
    } id_ex_t;

    // bypass from mem/wb
    typedef struct packed {
        logic            sel;
        logic [xlen-1:0] data;
    } fwd_t;

    typedef struct packed {
        logic ex_stop;
        logic mem_stop;
    } stall_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } bp_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic ov;
        logic adel;
        logic ades;
    } exc_t;

    typedef struct packed {
        logic            en;
        logic            wen;
        logic [3:0]      sel;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
    } dmem_req_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        mem_op_t               mem_op;
        logic                  rf_we;
        logic [reg_addr_w-1:0] rf_waddr;
        logic [xlen-1:0]       result;
        exc_t                  exc;
        logic [xlen-1:0]       bad_vaddr;
    } ex_mem_t;

endpackage

//--- hw/ex_isa_pkg.sv
package ex_isa_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    // link address and not-taken fall-through both sit two words past pc
    localparam logic [xlen-1:0] link_offset = 32'd8;

    typedef enum logic [3:0] {
        alu_add, alu_addu, alu_sub, alu_subu,
        alu_and, alu_or, alu_xor, alu_nor,
        alu_slt, alu_sltu, alu_sll, alu_srl,
        alu_sra, alu_lui, alu_pass_b
    } alu_op_t;

    typedef enum logic [1:0] {src1_rs, src1_pc, src1_shamt} src1_sel_t;

    typedef enum logic [1:0] {src2_rt, src2_imm_sext, src2_link, src2_imm_zext} src2_sel_t;

    // none first so that a zeroed bubble decodes as no branch
    typedef enum logic [3:0] {
        br_none, br_beq, br_bne, br_bgez, br_bgtz, br_blez, br_bltz, br_j, br_jr
    } br_op_t;

    typedef enum logic [3:0] {
        mem_none, mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw, mem_sb, mem_sh, mem_sw
    } mem_op_t;

    // shamt lives in imm16[10:6]
    typedef struct packed {
        logic [5:0]            opcode;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [15:0]           imm16;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index26;
    } j_fmt_t;

    typedef union packed {
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } inst_word_u;

endpackage

//--- hw/ex_mem_request.sv
`timescale 1ns/1ps

module ex_mem_request (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush_i,
    input  ex_bus_pkg::id_ex_t          cur_i,
    input  logic [ex_isa_pkg::xlen-1:0] rt_val_i,
    input  logic [ex_isa_pkg::xlen-1:0] result_i,
    input  logic                        ov_i,
    output ex_bus_pkg::dmem_req_t       dmem_req_o,
    output ex_bus_pkg::ex_mem_t         ex_mem_o
);

    import ex_isa_pkg::*;
    import ex_bus_pkg::*;

    logic [1:0]      lane;
    logic [3:0]      half_sel;
    logic [3:0]      sel;
    logic [xlen-1:0] wdata;
    logic            is_mem;
    logic            is_store;
    logic            half_ld;
    logic            half_st;
    logic            word_ld;
    logic            word_st;
    exc_t            exc;
    logic            store_block;

    assign lane     = result_i[1:0];
    assign half_sel = lane[0] ? 4'b0000 : (lane[1] ? 4'b1100 : 4'b0011);

    assign is_mem   = cur_i.mem_op != mem_none;
    assign is_store = (cur_i.mem_op == mem_sb) || (cur_i.mem_op == mem_sh)
                   || (cur_i.mem_op == mem_sw);
    assign half_ld  = (cur_i.mem_op == mem_lh) || (cur_i.mem_op == mem_lhu);
    assign half_st  = cur_i.mem_op == mem_sh;
    assign word_ld  = cur_i.mem_op == mem_lw;
    assign word_st  = cur_i.mem_op == mem_sw;

    // lane select, store data copied to every lane
    always_comb begin
        sel   = 4'b0000;
        wdata = '0;
        case (cur_i.mem_op)
            mem_lb, mem_lbu: sel = 4'b0001 << lane;
            mem_lh, mem_lhu: sel = half_sel;
            mem_lw:          sel = 4'b1111;
            mem_sb: begin
                sel   = 4'b0001 << lane;
                wdata = {4{rt_val_i[7:0]}};
            end
            mem_sh: begin
                sel   = half_sel;
                wdata = {2{rt_val_i[15:0]}};
            end
            mem_sw: begin
                sel   = 4'b1111;
                wdata = rt_val_i;
            end
            default: sel = 4'b0000;
        endcase
    end

    assign exc.ov   = cur_i.valid && ov_i;
    assign exc.adel = cur_i.valid && ((half_ld && lane[0]) || (word_ld && (lane != 2'b00)));
    assign exc.ades = cur_i.valid && ((half_st && lane[0]) || (word_st && (lane != 2'b00)));

    // once something faults, memory stays quiet until the pipe is flushed
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            store_block <= 1'b0;
        end else if (exc != '0) begin
            store_block <= 1'b1;
        end
    end

    always_comb begin
        dmem_req_o.en    = cur_i.valid && is_mem && (exc == '0) && !store_block;
        dmem_req_o.wen   = cur_i.valid && is_store;
        dmem_req_o.sel   = sel;
        dmem_req_o.addr  = result_i;
        dmem_req_o.wdata = wdata;
    end

    always_comb begin
        ex_mem_o.valid     = cur_i.valid;
        ex_mem_o.pc        = cur_i.pc;
        ex_mem_o.mem_op    = cur_i.mem_op;
        ex_mem_o.rf_we     = cur_i.rf_we;
        ex_mem_o.rf_waddr  = cur_i.rf_waddr;
        ex_mem_o.result    = result_i;
        ex_mem_o.exc       = exc;
        ex_mem_o.bad_vaddr = result_i;
    end

endmodule

//--- hw/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush_i,
    input  ex_bus_pkg::stall_t    stall_i,
    input  ex_bus_pkg::id_ex_t    id_ex_i,
    input  ex_bus_pkg::fwd_t      fwd_rs_i,
    input  ex_bus_pkg::fwd_t      fwd_rt_i,
    input  ex_bus_pkg::bp_t       bp_i,
    output ex_bus_pkg::redirect_t redirect_o,
    output ex_bus_pkg::dmem_req_t dmem_req_o,
    output ex_bus_pkg::ex_mem_t   ex_mem_o
);

    import ex_isa_pkg::*;
    import ex_bus_pkg::*;

    id_ex_t          cur;
    logic [xlen-1:0] rs_val;
    logic [xlen-1:0] rt_val;
    logic [xlen-1:0] alu_result;
    logic            alu_ov;

    ex_stage_reg u_reg (
        .clk     (clk),
        .rst     (rst),
        .flush_i (flush_i),
        .stall_i (stall_i),
        .id_ex_i (id_ex_i),
        .cur_o   (cur)
    );

    ex_alu u_alu (
        .cur_i    (cur),
        .fwd_rs_i (fwd_rs_i),
        .fwd_rt_i (fwd_rt_i),
        .rs_val_o (rs_val),
        .rt_val_o (rt_val),
        .result_o (alu_result),
        .ov_o     (alu_ov)
    );

    ex_branch_resolve u_br (
        .cur_i      (cur),
        .rs_val_i   (rs_val),
        .rt_val_i   (rt_val),
        .bp_i       (bp_i),
        .redirect_o (redirect_o)
    );

    ex_mem_request u_mem (
        .clk        (clk),
        .rst        (rst),
        .flush_i    (flush_i),
        .cur_i      (cur),
        .rt_val_i   (rt_val),
        .result_i   (alu_result),
        .ov_i       (alu_ov),
        .dmem_req_o (dmem_req_o),
        .ex_mem_o   (ex_mem_o)
    );

endmodule

//--- hw/ex_stage_reg.sv
`timescale 1ns/1ps

module ex_stage_reg (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush_i,
    input  ex_bus_pkg::stall_t stall_i,
    input  ex_bus_pkg::id_ex_t id_ex_i,
    output ex_bus_pkg::id_ex_t cur_o
);

    logic insert_bubble;
    logic hold;

    // ex stalled but mem moving on, so a bubble goes down the pipe
    assign insert_bubble = stall_i.ex_stop && !stall_i.mem_stop;
    assign hold          = stall_i.ex_stop && stall_i.mem_stop;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            cur_o <= '0;
        end else if (insert_bubble) begin
            cur_o <= '0;
        end else if (!hold) begin
            cur_o <= id_ex_i;
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f ex_stage.f --top-module ex_stage_tb -o ex_stage_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

# let every bound assertion failure reach the end of the run
output=$(./obj_dir/ex_stage_sim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF "All tests passed!"; then
    exit 0
fi
exit 1

//--- verif/ex_stage_checker.sv
`timescale 1ns/1ps

module ex_stage_checker (
    input logic                  clk,
    input logic                  rst,
    input logic                  flush_i,
    input ex_bus_pkg::redirect_t redirect_i,
    input ex_bus_pkg::dmem_req_t dmem_req_i,
    input ex_bus_pkg::ex_mem_t   ex_mem_i
);

    import ex_isa_pkg::*;

    int fail_count = 0;

    // no request goes out next to an exception
    a_en_no_exc: assert property (@(posedge clk) disable iff (rst)
        dmem_req_i.en |-> (ex_mem_i.exc == '0))
    else begin
        fail_count++;
        $error("dmem_req_o.en high with ex_mem_o.exc = %h", ex_mem_i.exc);
    end

    // flush leaves a bubble behind
    a_flush_quiet: assert property (@(posedge clk) disable iff (rst)
        flush_i |=> (!redirect_i.valid && !dmem_req_i.en))
    else begin
        fail_count++;
        $error("redirect or dmem request active in the cycle after a flush");
    end

    a_sb_onehot: assert property (@(posedge clk) disable iff (rst)
        (dmem_req_i.wen && (ex_mem_i.mem_op == mem_sb)) |-> $onehot(dmem_req_i.sel))
    else begin
        fail_count++;
        $error("byte store with dmem_req_o.sel = %h", dmem_req_i.sel);
    end

endmodule

//--- verif/ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb;

    import ex_isa_pkg::*;
    import ex_bus_pkg::*;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 5;
    localparam int phase_cycles = 500;
    // five random phases plus the short store block sequence
    localparam int total_cycles = reset_cycles + 5 * phase_cycles + 20;
    localparam int watchdog_ns  = (total_cycles + 100) * clk_period;

    typedef struct packed {
        redirect_t redirect;
        dmem_req_t dmem_req;
        ex_mem_t   ex_mem;
    } outputs_t;

    logic      clk;
    logic      rst;
    logic      flush;
    stall_t    stall;
    id_ex_t    id_ex;
    fwd_t      fwd_rs;
    fwd_t      fwd_rt;
    bp_t       bp;
    redirect_t redirect;
    dmem_req_t dmem_req;
    ex_mem_t   ex_mem;

    // model copy of the stage register and the store block
    id_ex_t m_cur;
    logic   m_block;

    int          test_errors;
    int          test_checks;
    int          tests_run;
    int          tests_failed;
    int          assert_fails;

    ex_stage dut0 (
        .clk        (clk),
        .rst        (rst),
        .flush_i    (flush),
        .stall_i    (stall),
        .id_ex_i    (id_ex),
        .fwd_rs_i   (fwd_rs),
        .fwd_rt_i   (fwd_rt),
        .bp_i       (bp),
        .redirect_o (redirect),
        .dmem_req_o (dmem_req),
        .ex_mem_o   (ex_mem)
    );

    bind ex_stage ex_stage_checker chk0 (
        .clk        (clk),
        .rst        (rst),
        .flush_i    (flush_i),
        .redirect_i (redirect_o),
        .dmem_req_i (dmem_req_o),
        .ex_mem_i   (ex_mem_o)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the run did not complete", watchdog_ns);
        $display("Test failures found");
        $finish;
    end

    function automatic logic [xlen-1:0] edge_value();
        case ($urandom_range(5, 0))
            0: return 32'h0000_0000;
            1: return 32'h7fff_ffff;
            2: return 32'h8000_0000;
            3: return 32'hffff_ffff;
            4: return $urandom_range(64, 0);
            default: return $urandom();
        endcase
    endfunction

    function automatic logic branch_taken(br_op_t op, logic [xlen-1:0] rs, logic [xlen-1:0] rt);
        case (op)
            br_beq: return rs == rt;
            br_bne: return rs != rt;
            br_bgez: return $signed(rs) >= 0;
            br_bgtz: return $signed(rs) > 0;
            br_blez: return $signed(rs) <= 0;
            br_bltz: return $signed(rs) < 0;
            br_j, br_jr: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [xlen-1:0] branch_target(id_ex_t c, logic [xlen-1:0] rs);
        logic [xlen-1:0] next_pc;
        next_pc = c.pc + 32'd4;
        case (c.br_op)
            br_j: return {next_pc[31:28], c.inst.j_fmt.index26, 2'b00};
            br_jr: return rs;
            default: return next_pc + ({{16{c.inst.i_fmt.imm16[15]}}, c.inst.i_fmt.imm16} << 2);
        endcase
    endfunction

    function automatic outputs_t expected_outputs(id_ex_t c, fwd_t frs, fwd_t frt, bp_t p,
                                                  logic blocked);
        outputs_t        o;
        logic [xlen-1:0] rs;
        logic [xlen-1:0] rt;
        logic [xlen-1:0] op1;
        logic [xlen-1:0] op2;
        logic [xlen-1:0] res;
        logic [xlen-1:0] tgt;
        longint          wide;
        logic            ov;
        logic            taken;
        logic            store;
        logic            misaligned;
        o = '0;
        rs = frs.sel ? frs.data : c.rs_data;
        rt = frt.sel ? frt.data : c.rt_data;
        case (c.src1_sel)
            src1_pc: op1 = c.pc;
            src1_shamt: op1 = {27'b0, c.inst.i_fmt.imm16[10:6]};
            default: op1 = rs;
        endcase
        case (c.src2_sel)
            src2_imm_sext: op2 = {{16{c.inst.i_fmt.imm16[15]}}, c.inst.i_fmt.imm16};
            src2_imm_zext: op2 = {16'h0000, c.inst.i_fmt.imm16};
            src2_link: op2 = 32'd8;
            default: op2 = rt;
        endcase
        ov = 1'b0;
        case (c.alu_op)
            alu_add, alu_addu, alu_sub, alu_subu: begin
                if (c.alu_op == alu_add || c.alu_op == alu_addu) begin
                    wide = longint'($signed(op1)) + longint'($signed(op2));
                end else begin
                    wide = longint'($signed(op1)) - longint'($signed(op2));
                end
                res = wide[31:0];
                // out of signed range if truncation changes the value
                ov = (c.alu_op == alu_add || c.alu_op == alu_sub)
                  && (wide != longint'($signed(res)));
            end
            alu_and: res = op1 & op2;
            alu_or: res = op1 | op2;
            alu_xor: res = op1 ^ op2;
            alu_nor: res = ~(op1 | op2);
            alu_slt: res = ($signed(op1) < $signed(op2)) ? 32'd1 : 32'd0;
            alu_sltu: res = (op1 < op2) ? 32'd1 : 32'd0;
            alu_sll: res = op2 << op1[4:0];
            alu_srl: res = op2 >> op1[4:0];
            alu_sra: res = $signed(op2) >>> op1[4:0];
            alu_lui: res = {op2[15:0], 16'h0000};
            alu_pass_b: res = op2;
            default: res = '0;
        endcase
        taken = branch_taken(c.br_op, rs, rt);
        tgt = branch_target(c, rs);
        if (c.valid && c.br_op != br_none) begin
            if (taken && (!p.taken || p.target != tgt)) begin
                o.redirect.valid = 1'b1;
                o.redirect.target = tgt;
            end else if (!taken && p.taken) begin
                o.redirect.valid = 1'b1;
                o.redirect.target = c.pc + 32'd8;
            end
        end
        store = c.mem_op inside {mem_sb, mem_sh, mem_sw};
        misaligned = 1'b0;
        case (c.mem_op)
            mem_lb, mem_lbu, mem_sb: o.dmem_req.sel = 4'b0001 << res[1:0];
            mem_lh, mem_lhu, mem_sh: begin
                misaligned = res[0];
                o.dmem_req.sel = res[0] ? 4'b0000 : (res[1] ? 4'b1100 : 4'b0011);
            end
            mem_lw, mem_sw: begin
                misaligned = res[1:0] != 2'b00;
                o.dmem_req.sel = 4'b1111;
            end
            default: o.dmem_req.sel = 4'b0000;
        endcase
        if (c.mem_op == mem_sb) o.dmem_req.wdata = {4{rt[7:0]}};
        if (c.mem_op == mem_sh) o.dmem_req.wdata = {2{rt[15:0]}};
        if (c.mem_op == mem_sw) o.dmem_req.wdata = rt;
        o.ex_mem.exc.ov = c.valid && ov;
        o.ex_mem.exc.adel = c.valid && misaligned && !store;
        o.ex_mem.exc.ades = c.valid && misaligned && store;
        o.dmem_req.en = c.valid && c.mem_op != mem_none && o.ex_mem.exc == '0 && !blocked;
        o.dmem_req.wen = c.valid && store;
        o.dmem_req.addr = res;
        o.ex_mem.valid = c.valid;
        o.ex_mem.pc = c.pc;
        o.ex_mem.mem_op = c.mem_op;
        o.ex_mem.rf_we = c.rf_we;
        o.ex_mem.rf_waddr = c.rf_waddr;
        o.ex_mem.result = res;
        o.ex_mem.bad_vaddr = res;
        return o;
    endfunction

    task automatic compare_outputs();
        outputs_t exp;
        exp = expected_outputs(m_cur, fwd_rs, fwd_rt, bp, m_block);
        test_checks++;
        assert (redirect == exp.redirect) else begin
            $display("** Error: redirect_o got %h expected %h", redirect, exp.redirect);
            test_errors++;
        end
        assert (dmem_req == exp.dmem_req) else begin
            $display("** Error: dmem_req_o got %h expected %h", dmem_req, exp.dmem_req);
            test_errors++;
        end
        assert (ex_mem == exp.ex_mem) else begin
            $display("** Error: ex_mem_o got %h expected %h", ex_mem, exp.ex_mem);
            test_errors++;
        end
    endtask

    // called at a falling edge, checks at the next one
    task automatic apply_cycle(input logic rst_v, input logic flush_v, input stall_t st,
                               input id_ex_t ins, input fwd_t frs, input fwd_t frt,
                               input bp_t p);
        outputs_t now;
        rst = rst_v;
        flush = flush_v;
        stall = st;
        id_ex = ins;
        fwd_rs = frs;
        fwd_rt = frt;
        bp = p;
        now = expected_outputs(m_cur, frs, frt, p, m_block);
        if (rst_v || flush_v) begin
            m_block = 1'b0;
            m_cur = '0;
        end else begin
            if (now.ex_mem.exc != '0) m_block = 1'b1;
            if (st.ex_stop && !st.mem_stop) m_cur = '0;
            else if (!st.ex_stop) m_cur = ins;
        end
        @(negedge clk);
        compare_outputs();
    endtask

    function automatic id_ex_t random_instr(int mode);
        id_ex_t i;
        i = '0;
        i.valid = $urandom_range(7, 0) != 0;
        i.pc = $urandom() & 32'hffff_fffc;
        i.inst = $urandom();
        i.alu_op = alu_op_t'(4'($urandom_range(14, 0)));
        i.src1_sel = src1_sel_t'(2'($urandom_range(2, 0)));
        i.src2_sel = src2_sel_t'(2'($urandom_range(3, 0)));
        i.rf_we = $urandom_range(1, 0) == 1;
        i.rf_waddr = 5'($urandom());
        i.rs_data = edge_value();
        i.rt_data = ($urandom_range(2, 0) == 0) ? i.rs_data : edge_value();
        if (mode == 2 || mode == 4) i.br_op = br_op_t'(4'($urandom_range(8, 0)));
        if (mode == 1 || mode == 3 || mode == 4) i.mem_op = mem_op_t'(4'($urandom_range(8, 0)));
        if (mode == 3) begin
            // base plus offset aligned three times in four
            i.src1_sel = src1_rs;
            i.src2_sel = src2_imm_sext;
            i.alu_op = alu_addu;
            if ($urandom_range(3, 0) != 0) begin
                i.rs_data &= 32'hffff_fffc;
                i.inst.i_fmt.imm16[1:0] = 2'b00;
            end
        end
        return i;
    endfunction

    function automatic fwd_t random_fwd();
        fwd_t f;
        f.sel = $urandom_range(1, 0) == 1;
        f.data = edge_value();
        return f;
    endfunction

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors != 0) tests_failed++;
        $display("test %s: %s, %0d checks, %0d errors", name,
                 (test_errors == 0) ? "PASS" : "FAIL", test_checks, test_errors);
    endtask

    // mode 0 alu, 1 forwarding, 2 branches, 3 memory, 4 stall and flush
    task automatic random_phase(input string name, input int mode);
        id_ex_t ins;
        fwd_t   frs;
        fwd_t   frt;
        bp_t    p;
        stall_t st;
        logic   fl;
        test_errors = 0;
        test_checks = 0;
        repeat (phase_cycles) begin
            ins = random_instr(mode);
            frs = '0;
            frt = '0;
            p = '0;
            st = '0;
            fl = 1'b0;
            if (mode == 1 || mode == 2 || mode == 4) begin
                frs = random_fwd();
                frt = random_fwd();
            end
            if (mode == 2 || mode == 4) begin
                p.taken = $urandom_range(1, 0) == 1;
                p.target = ($urandom_range(1, 0) == 1)
                         ? branch_target(ins, frs.sel ? frs.data : ins.rs_data) : $urandom();
            end
            if (mode == 4) st = 2'($urandom());
            if (mode != 0) fl = $urandom_range(5, 0) == 0;
            apply_cycle(1'b0, fl, st, ins, frs, frt, p);
        end
        end_test(name);
    endtask

    function automatic id_ex_t mem_access(mem_op_t op, logic [xlen-1:0] addr);
        id_ex_t i;
        i = '0;
        i.valid = 1'b1;
        i.pc = 32'h0000_0400;
        i.alu_op = alu_addu;
        i.src1_sel = src1_rs;
        i.src2_sel = src2_imm_sext;
        i.mem_op = op;
        i.rs_data = addr;
        i.rt_data = 32'h1234_5678;
        return i;
    endfunction

    task automatic store_block_seq();
        test_errors = 0;
        test_checks = 0;
        // mid-run reset clears whatever the memory phase left behind
        apply_cycle(1'b1, 1'b0, '0, '0, '0, '0, '0);
        apply_cycle(1'b0, 1'b0, '0, mem_access(mem_lw, 32'h0000_1002), '0, '0, '0);
        repeat (6) begin
            apply_cycle(1'b0, 1'b0, '0, mem_access(mem_sw, 32'h0000_2000), '0, '0, '0);
            assert (!dmem_req.en) else begin
                $display("store block: aligned store reached memory before a flush");
                test_errors++;
            end
        end
        apply_cycle(1'b0, 1'b1, '0, mem_access(mem_sw, 32'h0000_2000), '0, '0, '0);
        apply_cycle(1'b0, 1'b0, '0, mem_access(mem_sw, 32'h0000_2000), '0, '0, '0);
        assert (dmem_req.en) else begin
            $display("store block: aligned store still held back after the flush");
            test_errors++;
        end
        end_test("store_block");
    endtask

    initial begin
        void'($urandom(32'hdaa6_7502));
        rst = 1'b1;
        flush = 1'b0;
        stall = '0;
        id_ex = '0;
        fwd_rs = '0;
        fwd_rt = '0;
        bp = '0;
        m_cur = '0;
        m_block = 1'b0;
        tests_run = 0;
        tests_failed = 0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        random_phase("alu", 0);
        random_phase("forwarding", 1);
        random_phase("branch", 2);
        random_phase("memory", 3);
        store_block_seq();
        random_phase("stall_flush", 4);
        assert_fails = dut0.chk0.fail_count;
        if (assert_fails != 0) begin
            $display("bound checker reported %0d assertion failures", assert_fails);
        end
        $display("tests run %0d, passed %0d, failed %0d, checker failures %0d",
                 tests_run, tests_run - tests_failed, tests_failed, assert_fails);
        if (tests_failed == 0 && assert_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
